// File: common/priv_config.svh
// Build options for the machine-mode privilege unit
// Hart id, floating-point CSR option and trap vector reset base

`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// Value returned by mhartid
`define PRIV_HARTID 32'h0000_0000

// Floating-point status CSRs
// 1 builds the fflags/frm/fcsr block and sets misa.F, 0 leaves both out
`define PRIV_FPU_CSR 1

// mtvec after reset
// Low two bits are the mode, so 0 here also means direct mode
`define PRIV_MTVEC_RESET 32'h0000_0000

`endif

// File: common/priv_pkg.sv
// Shared types and constants of the machine-mode privilege unit
// CSR words, privilege levels, mtvec modes, CSR map, cause codes, misa bits

package priv_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [63:0] long_csr_t;
  typedef logic [31:0] cause_t;   // Bit 31 set for interrupts

  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    M_MODE = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  // Machine information
  localparam csr_addr_t MVENDORID_ADDR      = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR        = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR         = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR        = 12'hF14;

  // Trap setup
  localparam csr_addr_t MSTATUS_ADDR        = 12'h300;
  localparam csr_addr_t MISA_ADDR           = 12'h301;
  localparam csr_addr_t MIE_ADDR            = 12'h304;
  localparam csr_addr_t MTVEC_ADDR          = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR     = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR  = 12'h320;

  // Trap handling
  localparam csr_addr_t MSCRATCH_ADDR       = 12'h340;
  localparam csr_addr_t MEPC_ADDR           = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR         = 12'h342;
  localparam csr_addr_t MTVAL_ADDR          = 12'h343;
  localparam csr_addr_t MIP_ADDR            = 12'h344;

  // Counters
  localparam csr_addr_t MCYCLE_ADDR         = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR       = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR        = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR      = 12'hB82;

  // Floating-point status, served by the extension
  localparam csr_addr_t FFLAGS_ADDR         = 12'h001;
  localparam csr_addr_t FRM_ADDR            = 12'h002;
  localparam csr_addr_t FCSR_ADDR           = 12'h003;

  // Interrupt cause codes, also the bit positions in mie and mip
  localparam cause_t IRQ_M_SOFT  = 32'd3;
  localparam cause_t IRQ_M_TIMER = 32'd7;
  localparam cause_t IRQ_M_EXT   = 32'd11;

  // misa fields
  localparam logic [1:0]  BASE_RV32  = 2'b01;
  localparam logic [25:0] MISA_EXT_F = 26'h000_0020;   // Bit 5
  localparam logic [25:0] MISA_EXT_I = 26'h000_0100;   // Bit 8

endpackage

// File: priv/priv_csr.sv
// Machine CSR file
// Holds the machine registers and 64-bit counters, forms write, set and
// clear results, legalizes WARL fields and checks access privilege.
// Addresses it does not own go out on the extension broadcast

`include "priv_config.svh"

module priv_csr (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   csr_addr,
  input  logic                  csr_write,
  input  logic                  csr_set,
  input  logic                  csr_clear,
  input  logic                  valid_write,
  input  priv_pkg::csr_word_t   new_csr_val,
  input  logic                  inst_ret,
  input  priv_pkg::priv_level_t curr_priv,
  input  logic                  inject_trap,
  input  logic                  inject_mret,
  input  priv_pkg::csr_word_t   next_mstatus,
  input  priv_pkg::csr_word_t   next_mepc,
  input  priv_pkg::csr_word_t   next_mcause,
  input  priv_pkg::csr_word_t   next_mtval,
  input  priv_pkg::csr_word_t   curr_mip_in,
  input  logic                  ext_ack,
  input  priv_pkg::csr_word_t   ext_value_out,
  input  logic                  ext_invalid,
  output priv_pkg::csr_word_t   old_csr_val,
  output logic                  invalid_csr,
  output priv_pkg::csr_word_t   curr_mstatus,
  output priv_pkg::csr_word_t   curr_mie,
  output priv_pkg::csr_word_t   curr_mtvec,
  output priv_pkg::csr_word_t   curr_mepc,
  output priv_pkg::csr_addr_t   ext_csr_addr,
  output priv_pkg::csr_word_t   ext_value_in,
  output logic                  ext_csr_active
);

  import priv_pkg::*;

  localparam csr_word_t MSTATUS_BITS = 32'h0000_1888;   // mpp, mpie, mie
  localparam csr_word_t IRQ_BITS     = (32'd1 << IRQ_M_SOFT) |
                                       (32'd1 << IRQ_M_TIMER) |
                                       (32'd1 << IRQ_M_EXT);

  csr_word_t mstatus_q, mstatus_d;
  csr_word_t mie_q, mie_d;
  csr_word_t mip_q;
  csr_word_t mtvec_q, mtvec_d;
  csr_word_t mscratch_q, mscratch_d;
  csr_word_t mepc_q, mepc_d;
  csr_word_t mcause_q, mcause_d;
  csr_word_t mtval_q, mtval_d;
  csr_word_t mcounteren_q, mcounteren_d;
  csr_word_t mcountinhibit_q, mcountinhibit_d;
  long_csr_t cycle_q, cycle_d;
  long_csr_t instret_q, instret_d;
  csr_word_t misa;
  csr_word_t nxt_csr_val;
  logic      csr_op;
  logic      priv_fault;
  logic      do_write;
  logic      csr_hit;

  assign misa = {BASE_RV32, 4'b0000,
                 MISA_EXT_I | ((`PRIV_FPU_CSR != 0) ? MISA_EXT_F : 26'd0)};

  assign csr_op     = csr_write | csr_set | csr_clear;
  // Machine addresses have bits 9:8 both set
  assign priv_fault = csr_op & (&csr_addr[9:8]) & (curr_priv != M_MODE);
  assign do_write   = valid_write & csr_op & ~priv_fault;

  assign invalid_csr = priv_fault | (csr_op & ~csr_hit & ~ext_ack) | ext_invalid;

  // Extension broadcast
  assign ext_csr_addr   = csr_addr;
  assign ext_value_in   = nxt_csr_val;
  assign ext_csr_active = valid_write & csr_op;

  always_comb begin
    if (csr_set)
      nxt_csr_val = old_csr_val | new_csr_val;
    else if (csr_clear)
      nxt_csr_val = old_csr_val & ~new_csr_val;
    else
      nxt_csr_val = new_csr_val;
  end

  // Software writes, then trap and mret updates on top
  always_comb begin
    mstatus_d       = mstatus_q;
    mie_d           = mie_q;
    mtvec_d         = mtvec_q;
    mscratch_d      = mscratch_q;
    mepc_d          = mepc_q;
    mcause_d        = mcause_q;
    mtval_d         = mtval_q;
    mcounteren_d    = mcounteren_q;
    mcountinhibit_d = mcountinhibit_q;

    if (do_write) begin
      case (csr_addr)
        MSTATUS_ADDR: begin
          mstatus_d = nxt_csr_val & MSTATUS_BITS;
          // No S mode here, so anything but M folds to U
          mstatus_d[12:11] = (nxt_csr_val[12:11] == M_MODE) ? M_MODE : U_MODE;
        end
        MTVEC_ADDR: begin
          mtvec_d = nxt_csr_val;
          if (nxt_csr_val[1:0] > VECTORED)
            mtvec_d[1:0] = DIRECT;
        end
        MIE_ADDR:           mie_d = nxt_csr_val & IRQ_BITS;
        MSCRATCH_ADDR:      mscratch_d = nxt_csr_val;
        MEPC_ADDR:          mepc_d = nxt_csr_val;
        MCAUSE_ADDR:        mcause_d = nxt_csr_val;
        MTVAL_ADDR:         mtval_d = nxt_csr_val;
        MCOUNTEREN_ADDR:    mcounteren_d = nxt_csr_val & 32'h0000_0007;
        MCOUNTINHIBIT_ADDR: mcountinhibit_d = nxt_csr_val & 32'h0000_0005;
        default: ;
      endcase
    end

    if (inject_trap) begin
      mstatus_d = next_mstatus;
      mepc_d    = next_mepc;
      mcause_d  = next_mcause;
      mtval_d   = next_mtval;
    end else if (inject_mret) begin
      mstatus_d = next_mstatus;
    end
  end

  always_comb begin
    cycle_d   = cycle_q;
    instret_d = instret_q;
    if (mcounteren_q[0] && !mcountinhibit_q[0])
      cycle_d = cycle_q + 64'd1;
    if (mcounteren_q[2] && !mcountinhibit_q[2])
      instret_d = instret_q + {63'd0, inst_ret};
    if (do_write) begin   // A write beats the increment
      case (csr_addr)
        MCYCLE_ADDR:    cycle_d[31:0]    = nxt_csr_val;
        MCYCLEH_ADDR:   cycle_d[63:32]   = nxt_csr_val;
        MINSTRET_ADDR:  instret_d[31:0]  = nxt_csr_val;
        MINSTRETH_ADDR: instret_d[63:32] = nxt_csr_val;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_q       <= 32'h0000_1800;   // mpp = M, interrupts off
      mie_q           <= '0;
      mip_q           <= '0;
      mtvec_q         <= `PRIV_MTVEC_RESET;
      mcause_q        <= '0;
      mcounteren_q    <= 32'h0000_0007;
      mcountinhibit_q <= '0;
      cycle_q         <= '0;
      instret_q       <= '0;
    end else begin
      mstatus_q       <= mstatus_d;
      mie_q           <= mie_d;
      mip_q           <= curr_mip_in & IRQ_BITS;   // Software writes ignored
      mtvec_q         <= mtvec_d;
      mcause_q        <= mcause_d;
      mcounteren_q    <= mcounteren_d;
      mcountinhibit_q <= mcountinhibit_d;
      cycle_q         <= cycle_d;
      instret_q       <= instret_d;
    end
  end

  always_ff @(posedge CLK) begin
    mscratch_q <= mscratch_d;
    mepc_q     <= mepc_d;
    mtval_q    <= mtval_d;
  end

  // Read mux
  always_comb begin
    old_csr_val = '0;
    csr_hit     = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR,
      MARCHID_ADDR,
      MIMPID_ADDR:        old_csr_val = '0;
      MHARTID_ADDR:       old_csr_val = `PRIV_HARTID;
      MSTATUS_ADDR:       old_csr_val = mstatus_q;
      MISA_ADDR:          old_csr_val = misa;
      MIE_ADDR:           old_csr_val = mie_q;
      MTVEC_ADDR:         old_csr_val = mtvec_q;
      MCOUNTEREN_ADDR:    old_csr_val = mcounteren_q;
      MCOUNTINHIBIT_ADDR: old_csr_val = mcountinhibit_q;
      MSCRATCH_ADDR:      old_csr_val = mscratch_q;
      MEPC_ADDR:          old_csr_val = mepc_q;
      MCAUSE_ADDR:        old_csr_val = mcause_q;
      MTVAL_ADDR:         old_csr_val = mtval_q;
      MIP_ADDR:           old_csr_val = mip_q;
      MCYCLE_ADDR:        old_csr_val = cycle_q[31:0];
      MCYCLEH_ADDR:       old_csr_val = cycle_q[63:32];
      MINSTRET_ADDR:      old_csr_val = instret_q[31:0];
      MINSTRETH_ADDR:     old_csr_val = instret_q[63:32];
      default: begin
        csr_hit = 1'b0;
        if (ext_ack)
          old_csr_val = ext_value_out;
      end
    endcase
  end

  assign curr_mstatus = mstatus_q;
  assign curr_mie     = mie_q;
  assign curr_mtvec   = mtvec_q;
  assign curr_mepc    = mepc_q;

endmodule

// File: priv/priv_trap_ctrl.sv
// Trap and interrupt controller
// Tracks the privilege level, arbitrates exception, mret and interrupts,
// and forms the single-cycle trap register updates and the fetch redirect

module priv_trap_ctrl (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  exception,
  input  priv_pkg::csr_word_t   ex_pc,
  input  priv_pkg::cause_t      ex_cause,
  input  priv_pkg::csr_word_t   ex_tval,
  input  logic                  mret,
  input  logic                  sw_irq,
  input  logic                  timer_irq,
  input  logic                  ext_irq,
  input  priv_pkg::csr_word_t   curr_mstatus,
  input  priv_pkg::csr_word_t   curr_mie,
  input  priv_pkg::csr_word_t   curr_mtvec,
  input  priv_pkg::csr_word_t   curr_mepc,
  output priv_pkg::priv_level_t curr_priv,
  output priv_pkg::csr_word_t   curr_mip_in,
  output logic                  inject_trap,
  output logic                  inject_mret,
  output priv_pkg::csr_word_t   next_mstatus,
  output priv_pkg::csr_word_t   next_mepc,
  output priv_pkg::csr_word_t   next_mcause,
  output priv_pkg::csr_word_t   next_mtval,
  output logic                  trap_taken,
  output logic                  mret_taken,
  output priv_pkg::csr_word_t   redirect_pc
);

  import priv_pkg::*;

  priv_level_t  priv_q, priv_d;
  csr_word_t    pending;
  cause_t       irq_code;
  logic         irq_valid;
  logic         irq_take;
  csr_word_t    mtvec_base;
  vector_mode_t mtvec_mode;

  assign curr_mip_in = (csr_word_t'(sw_irq) << IRQ_M_SOFT) |
                       (csr_word_t'(timer_irq) << IRQ_M_TIMER) |
                       (csr_word_t'(ext_irq) << IRQ_M_EXT);
  assign pending = curr_mip_in & curr_mie;

  // External first, then software, then timer
  always_comb begin
    irq_valid = curr_mstatus[3];
    irq_code  = IRQ_M_EXT;
    if (pending[IRQ_M_EXT])
      irq_code = IRQ_M_EXT;
    else if (pending[IRQ_M_SOFT])
      irq_code = IRQ_M_SOFT;
    else if (pending[IRQ_M_TIMER])
      irq_code = IRQ_M_TIMER;
    else
      irq_valid = 1'b0;
  end

  assign mret_taken  = mret & ~exception;
  assign irq_take    = irq_valid & ~exception & ~mret;
  assign trap_taken  = exception | irq_take;
  assign inject_trap = trap_taken;
  assign inject_mret = mret_taken;

  always_comb begin
    next_mstatus = curr_mstatus;
    if (mret_taken) begin
      next_mstatus[3]     = curr_mstatus[7];   // mie <- mpie
      next_mstatus[7]     = 1'b1;
      next_mstatus[12:11] = U_MODE;
    end else begin
      next_mstatus[7]     = curr_mstatus[3];   // mpie <- mie
      next_mstatus[3]     = 1'b0;
      next_mstatus[12:11] = priv_q;
    end
  end

  // Interrupts land on the PC of the request that would have gone next
  assign next_mepc   = ex_pc;
  assign next_mcause = exception ? ex_cause : {1'b1, irq_code[30:0]};
  assign next_mtval  = exception ? ex_tval : '0;

  assign mtvec_base = {curr_mtvec[31:2], 2'b00};
  assign mtvec_mode = vector_mode_t'(curr_mtvec[1:0]);

  always_comb begin
    if (mret_taken)
      redirect_pc = curr_mepc;
    else if (irq_take && mtvec_mode == VECTORED)
      redirect_pc = mtvec_base + (irq_code << 2);
    else
      redirect_pc = mtvec_base;
  end

  always_comb begin
    priv_d = priv_q;
    if (trap_taken)
      priv_d = M_MODE;
    else if (mret_taken)
      priv_d = priv_level_t'(curr_mstatus[12:11]);   // mpp holds only M or U
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      priv_q <= M_MODE;
    else
      priv_q <= priv_d;
  end

  assign curr_priv = priv_q;

endmodule

// File: priv/priv_fcsr_ext.sv
// Floating-point status CSR extension
// Holds fflags and frm and serves fflags, frm and fcsr on the extension bus

module priv_fcsr_ext (
  input  logic                CLK,
  input  logic                nRST,
  input  priv_pkg::csr_addr_t ext_csr_addr,
  input  priv_pkg::csr_word_t ext_value_in,
  input  logic                ext_csr_active,
  output logic                ext_ack,
  output priv_pkg::csr_word_t ext_value_out,
  output logic                ext_invalid
);

  import priv_pkg::*;

  logic [4:0] fflags_q;
  logic [2:0] frm_q;
  logic [2:0] frm_new;
  logic       hit_fflags;
  logic       hit_frm;
  logic       hit_fcsr;
  logic       frm_bad;

  assign hit_fflags = (ext_csr_addr == FFLAGS_ADDR);
  assign hit_frm    = (ext_csr_addr == FRM_ADDR);
  assign hit_fcsr   = (ext_csr_addr == FCSR_ADDR);
  assign ext_ack    = hit_fflags | hit_frm | hit_fcsr;

  // fcsr carries frm in bits 7:5
  assign frm_new     = hit_fcsr ? ext_value_in[7:5] : ext_value_in[2:0];
  assign frm_bad     = (hit_frm | hit_fcsr) && (frm_new == 3'd5 || frm_new == 3'd6);
  assign ext_invalid = ext_csr_active & frm_bad;

  always_comb begin
    ext_value_out = '0;
    if (hit_fflags)
      ext_value_out[4:0] = fflags_q;
    else if (hit_frm)
      ext_value_out[2:0] = frm_q;
    else if (hit_fcsr)
      ext_value_out[7:0] = {frm_q, fflags_q};
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else if (ext_csr_active && !frm_bad) begin   // Bad frm drops whole write
      if (hit_fflags || hit_fcsr)
        fflags_q <= ext_value_in[4:0];
      if (hit_frm || hit_fcsr)
        frm_q <= frm_new;
    end
  end

endmodule

// File: design/priv_unit.sv
// Machine-mode privilege unit
// CSR file, trap controller and the optional floating-point status CSRs

`include "priv_config.svh"

module priv_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   csr_addr,
  input  logic                  csr_write,
  input  logic                  csr_set,
  input  logic                  csr_clear,
  input  priv_pkg::csr_word_t   new_csr_val,
  input  logic                  valid_write,
  input  logic                  inst_ret,
  input  priv_pkg::csr_word_t   ex_pc,
  input  logic                  exception,
  input  priv_pkg::cause_t      ex_cause,
  input  priv_pkg::csr_word_t   ex_tval,
  input  logic                  mret,
  input  logic                  sw_irq,
  input  logic                  timer_irq,
  input  logic                  ext_irq,
  output priv_pkg::csr_word_t   old_csr_val,
  output logic                  invalid_csr,
  output logic                  trap_taken,
  output logic                  mret_taken,
  output priv_pkg::csr_word_t   redirect_pc,
  output priv_pkg::priv_level_t curr_priv
);

  import priv_pkg::*;

  logic      inject_trap, inject_mret;
  csr_word_t next_mstatus, next_mepc, next_mcause, next_mtval;
  csr_word_t curr_mip_in;
  csr_word_t curr_mstatus, curr_mie, curr_mtvec, curr_mepc;
  csr_addr_t ext_csr_addr;
  csr_word_t ext_value_in, ext_value_out;
  logic      ext_csr_active, ext_ack, ext_invalid;

  priv_csr csr_i (
    .CLK, .nRST,
    .csr_addr, .csr_write, .csr_set, .csr_clear, .valid_write, .new_csr_val,
    .inst_ret, .curr_priv,
    .inject_trap, .inject_mret,
    .next_mstatus, .next_mepc, .next_mcause, .next_mtval, .curr_mip_in,
    .ext_ack, .ext_value_out, .ext_invalid,
    .old_csr_val, .invalid_csr,
    .curr_mstatus, .curr_mie, .curr_mtvec, .curr_mepc,
    .ext_csr_addr, .ext_value_in, .ext_csr_active
  );

  priv_trap_ctrl trap_i (
    .CLK, .nRST,
    .exception, .ex_pc, .ex_cause, .ex_tval, .mret,
    .sw_irq, .timer_irq, .ext_irq,
    .curr_mstatus, .curr_mie, .curr_mtvec, .curr_mepc,
    .curr_priv, .curr_mip_in, .inject_trap, .inject_mret,
    .next_mstatus, .next_mepc, .next_mcause, .next_mtval,
    .trap_taken, .mret_taken, .redirect_pc
  );

  if (`PRIV_FPU_CSR != 0) begin : g_fcsr
    priv_fcsr_ext fcsr_i (
      .CLK, .nRST,
      .ext_csr_addr, .ext_value_in, .ext_csr_active,
      .ext_ack, .ext_value_out, .ext_invalid
    );
  end else begin : g_no_fcsr
    // No extension: every unknown address stays unknown
    assign ext_ack       = 1'b0;
    assign ext_invalid   = 1'b0;
    assign ext_value_out = '0;
  end

endmodule

// File: tests/priv_unit_assert.sv
// Concurrent checks on the privilege unit top level
// Trap and mret exclusion, quiet invalid_csr in reset, legal privilege level

module priv_unit_assert (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  trap_taken,
  input logic                  mret_taken,
  input logic                  invalid_csr,
  input priv_pkg::priv_level_t curr_priv
);

  import priv_pkg::*;

  int fail_count = 0;   // Failed assertion count

  trap_mret_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(trap_taken && mret_taken))
    else begin
      fail_count++;
      $error("trap_taken and mret_taken high in the same cycle");
    end

  quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !invalid_csr)
    else begin
      fail_count++;
      $error("invalid_csr high during reset");
    end

  legal_priv: assert property (@(posedge CLK) disable iff (!nRST)
    (curr_priv == M_MODE) || (curr_priv == U_MODE))
    else begin
      fail_count++;
      $error("curr_priv is neither M nor U mode");
    end

endmodule

bind priv_unit priv_unit_assert assert_i (.*);

// File: tests/priv_unit_tb.sv
// Directed testbench for the machine-mode privilege unit
// Covers identity CSRs, write/set/clear, floating-point CSRs, traps,
// interrupts and the performance counters

`include "priv_config.svh"

module priv_unit_tb;

  import priv_pkg::*;

  localparam int OP_WRITE  = 1;
  localparam int OP_SET    = 2;
  localparam int OP_CLEAR  = 3;
  localparam int MAX_CYCLES = 2000;   // Tests take about 400

  logic        CLK;
  logic        nRST;
  csr_addr_t   csr_addr;
  logic        csr_write, csr_set, csr_clear, valid_write;
  csr_word_t   new_csr_val;
  logic        inst_ret;
  csr_word_t   ex_pc, ex_tval;
  cause_t      ex_cause;
  logic        exception, mret;
  logic        sw_irq, timer_irq, ext_irq;
  csr_word_t   old_csr_val, redirect_pc;
  logic        invalid_csr, trap_taken, mret_taken;
  priv_level_t curr_priv;
  int          cycles;
  int unsigned seed_val;

  priv_unit dut_i (.*);

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d clock cycles", cycles);
      $display("Something failed");
      $fatal(1, "Timeout");
    end
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // One CSR operation with valid_write, old value and invalid flag sampled mid-cycle
  task automatic csr_access(input csr_addr_t addr, input int op, input csr_word_t data,
                            output csr_word_t old, output logic inv);
    @(posedge CLK);
    csr_addr    <= addr;
    csr_write   <= (op == OP_WRITE);
    csr_set     <= (op == OP_SET);
    csr_clear   <= (op == OP_CLEAR);
    new_csr_val <= data;
    valid_write <= 1'b1;
    @(negedge CLK);
    old = old_csr_val;
    inv = invalid_csr;
    @(posedge CLK);   // Write lands here
    csr_write   <= 1'b0;
    csr_set     <= 1'b0;
    csr_clear   <= 1'b0;
    valid_write <= 1'b0;
  endtask

  task automatic write_ok(input csr_addr_t addr, input int op, input csr_word_t data);
    csr_word_t old;
    logic      inv;
    csr_access(addr, op, data, old, inv);
    check("invalid_csr on legal access", inv, 1'b0);
  endtask

  task automatic read_csr(input csr_addr_t addr, output csr_word_t val);
    @(posedge CLK);
    csr_addr <= addr;
    @(negedge CLK);
    val = old_csr_val;
  endtask

  task automatic expect_csr(input string what, input csr_addr_t addr, input csr_word_t exp);
    csr_word_t val;
    read_csr(addr, val);
    check(what, val, exp);
  endtask

  task automatic take_exception(input csr_word_t pc, input cause_t cause,
                                input csr_word_t tval, input csr_word_t exp_pc);
    @(posedge CLK);
    exception <= 1'b1;
    ex_pc     <= pc;
    ex_cause  <= cause;
    ex_tval   <= tval;
    @(negedge CLK);
    check("trap_taken on exception", trap_taken, 1'b1);
    check("redirect_pc on exception", redirect_pc, exp_pc);
    @(posedge CLK);
    exception <= 1'b0;
  endtask

  task automatic pulse_inst_ret(input int n);
    repeat (n) begin
      @(posedge CLK);
      inst_ret <= 1'b1;
      @(posedge CLK);
      inst_ret <= 1'b0;
    end
  endtask

  task automatic reset_identity();
    csr_word_t status;
    @(negedge CLK);
    check("curr_priv after reset", curr_priv, M_MODE);
    check("trap_taken after reset", trap_taken, 1'b0);
    check("mret_taken after reset", mret_taken, 1'b0);
    check("invalid_csr after reset", invalid_csr, 1'b0);
    expect_csr("mhartid", MHARTID_ADDR, `PRIV_HARTID);
    expect_csr("mvendorid", MVENDORID_ADDR, 32'h0);
    expect_csr("marchid", MARCHID_ADDR, 32'h0);
    expect_csr("mimpid", MIMPID_ADDR, 32'h0);
    // RV32 in bits 31:30, I is bit 8, F is bit 5
    expect_csr("misa", MISA_ADDR, (32'd1 << 30) | (32'd1 << 8) | (32'd1 << 5));
    read_csr(MSTATUS_ADDR, status);
    check("mstatus.mie after reset", status[3], 1'b0);
  endtask

  task automatic rw_model(input string what, input csr_addr_t addr);
    csr_word_t model, data, old;
    logic      inv;
    data = $urandom;
    csr_access(addr, OP_WRITE, data, old, inv);
    check({what, " write invalid"}, inv, 1'b0);
    model = data;
    expect_csr({what, " after write"}, addr, model);
    data = $urandom;
    csr_access(addr, OP_SET, data, old, inv);
    check({what, " old value on set"}, old, model);
    model = model | data;
    expect_csr({what, " after set"}, addr, model);
    data = $urandom;
    csr_access(addr, OP_CLEAR, data, old, inv);
    check({what, " old value on clear"}, old, model);
    model = model & ~data;
    expect_csr({what, " after clear"}, addr, model);
  endtask

  task automatic write_set_clear();
    rw_model("mscratch", MSCRATCH_ADDR);
    rw_model("mepc", MEPC_ADDR);
    write_ok(MSTATUS_ADDR, OP_WRITE, 32'h0000_1000);   // mpp = 2
    expect_csr("mstatus with mpp 2", MSTATUS_ADDR, 32'h0000_0000);
    write_ok(MTVEC_ADDR, OP_WRITE, 32'h0000_1003);     // Mode 3
    expect_csr("mtvec with mode 3", MTVEC_ADDR, 32'h0000_1000);
  endtask

  task automatic fp_csrs();
    csr_word_t old;
    logic      inv;
    write_ok(FCSR_ADDR, OP_WRITE, 32'h0000_0075);      // frm 3, fflags 0x15
    expect_csr("fflags from fcsr", FFLAGS_ADDR, 32'h0000_0015);
    expect_csr("frm from fcsr", FRM_ADDR, 32'h0000_0003);
    expect_csr("fcsr", FCSR_ADDR, 32'h0000_0075);
    csr_access(FRM_ADDR, OP_WRITE, 32'h0000_0005, old, inv);
    check("invalid_csr on reserved frm", inv, 1'b1);
    expect_csr("frm after reserved write", FRM_ADDR, 32'h0000_0003);
    csr_access(12'h7C0, OP_WRITE, $urandom, old, inv);
    check("invalid_csr on unknown address", inv, 1'b1);
  endtask

  task automatic trap_and_mret();
    csr_word_t pc, tval, keep, old;
    logic      inv;
    pc   = $urandom & ~32'h3;
    tval = $urandom;
    write_ok(MTVEC_ADDR, OP_WRITE, 32'h0000_0100);     // Direct
    write_ok(MSTATUS_ADDR, OP_WRITE, 32'h0000_1808);   // mpp M, mie on
    take_exception(pc, 32'd2, tval, 32'h0000_0100);
    expect_csr("mepc after trap", MEPC_ADDR, pc);
    expect_csr("mcause after trap", MCAUSE_ADDR, 32'd2);
    expect_csr("mtval after trap", MTVAL_ADDR, tval);
    expect_csr("mstatus after trap", MSTATUS_ADDR, 32'h0000_1880);
    write_ok(MSTATUS_ADDR, OP_CLEAR, 32'h0000_1800);   // mpp to U
    @(posedge CLK);
    mret <= 1'b1;
    @(negedge CLK);
    check("mret_taken", mret_taken, 1'b1);
    check("redirect_pc on mret", redirect_pc, pc);
    @(posedge CLK);
    mret <= 1'b0;
    @(negedge CLK);
    check("curr_priv after mret", curr_priv, U_MODE);
    expect_csr("mstatus after mret", MSTATUS_ADDR, 32'h0000_0088);
    // Machine CSR write from U mode is refused
    read_csr(MSCRATCH_ADDR, keep);
    csr_access(MSCRATCH_ADDR, OP_WRITE, ~keep, old, inv);
    check("invalid_csr on U-mode write", inv, 1'b1);
    expect_csr("mscratch after U-mode write", MSCRATCH_ADDR, keep);
    take_exception(pc + 32'd4, 32'd8, 32'h0, 32'h0000_0100);   // Back to M
    @(negedge CLK);
    check("curr_priv after second trap", curr_priv, M_MODE);
  endtask

  task automatic interrupts();
    csr_word_t irq_pc, base;
    irq_pc = $urandom & ~32'h3;
    base   = 32'h0000_0200;
    write_ok(MTVEC_ADDR, OP_WRITE, base | 32'h1);      // Vectored
    write_ok(MIE_ADDR, OP_WRITE, 32'h0000_0080);       // Timer only
    @(posedge CLK);
    timer_irq <= 1'b1;
    ex_pc     <= irq_pc;
    repeat (4) begin
      @(negedge CLK);
      check("trap_taken with mstatus.mie clear", trap_taken, 1'b0);
    end
    expect_csr("mip with timer pending", MIP_ADDR, 32'h0000_0080);
    write_ok(MSTATUS_ADDR, OP_SET, 32'h0000_0008);
    @(negedge CLK);
    check("trap_taken on timer interrupt", trap_taken, 1'b1);
    check("redirect_pc on timer interrupt", redirect_pc, base + 32'd4 * 32'd7);
    @(posedge CLK);
    timer_irq <= 1'b0;
    expect_csr("mcause after interrupt", MCAUSE_ADDR, 32'h8000_0007);
    expect_csr("mepc after interrupt", MEPC_ADDR, irq_pc);
    expect_csr("mstatus after interrupt", MSTATUS_ADDR, 32'h0000_1880);
  endtask

  task automatic counters();
    csr_word_t first, second;
    int        n;
    n = $urandom_range(20, 5);
    read_csr(MCYCLE_ADDR, first);
    repeat (n) @(negedge CLK);
    second = old_csr_val;
    check("mcycle difference", second - first, n);
    read_csr(MINSTRET_ADDR, first);
    pulse_inst_ret(n);
    expect_csr("minstret after pulses", MINSTRET_ADDR, first + n);
    write_ok(MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h0000_0005);
    read_csr(MCYCLE_ADDR, first);
    repeat (n) @(negedge CLK);
    check("mcycle while inhibited", old_csr_val, first);
    read_csr(MINSTRET_ADDR, first);
    pulse_inst_ret(n);
    expect_csr("minstret while inhibited", MINSTRET_ADDR, first);
    write_ok(MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h0000_0000);
  endtask

  initial begin
    seed_val    = $urandom(32'h5aca);
    cycles      = 0;
    CLK         = 1'b0;
    nRST        = 1'b0;
    csr_addr    = '0;
    csr_write   = 1'b0;
    csr_set     = 1'b0;
    csr_clear   = 1'b0;
    valid_write = 1'b0;
    new_csr_val = '0;
    inst_ret    = 1'b0;
    ex_pc       = '0;
    exception   = 1'b0;
    ex_cause    = '0;
    ex_tval     = '0;
    mret        = 1'b0;
    sw_irq      = 1'b0;
    timer_irq   = 1'b0;
    ext_irq     = 1'b0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    reset_identity();
    write_set_clear();
    fp_csrs();
    trap_and_mret();
    interrupts();
    counters();
    if (dut_i.assert_i.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "Bound assertions reported errors");
    end
  end

endmodule

// File: verilog.f
+incdir+common
common/priv_pkg.sv
priv/priv_csr.sv
priv/priv_trap_ctrl.sv
priv/priv_fcsr_ext.sv
design/priv_unit.sv
tests/priv_unit_assert.sv
tests/priv_unit_tb.sv

// File: Bender.yml
package:
  name: priv_unit

export_include_dirs:
  - common

sources:
  - files:
      - common/priv_pkg.sv
      - priv/priv_csr.sv
      - priv/priv_trap_ctrl.sv
      - priv/priv_fcsr_ext.sv
      - design/priv_unit.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/priv_unit_assert.sv
      - tests/priv_unit_tb.sv
